// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/cache_arrays.sv
      - hdl/line_mover.sv
      - hdl/dcache_ctrl.sv
      - hdl/dcache_top.sv
  - target: simulation
    files:
      - bench/clk_gen.sv
      - bench/mem_model.sv
      - bench/dcache_tb.sv

// File: bench/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/dcache_tb.sv
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import dcache_pkg::*;

    localparam word_t      FILL_KEY   = 32'h5a3c_96e1;
    localparam int         MEM_WORDS  = 1 << 14;
    localparam int         HIT_CYCLES = 2;
    localparam int         MAX_WAIT   = 3;
    // two lines of gap, request, waits and ack per word plus lookup overhead
    localparam int         MISS_WORST = 2 * LINE_WORDS * (MAX_WAIT + 4) + 12;
    localparam int         RAND_STEPS = 40;
    localparam addr_t      LINE_A     = 32'h0000_1060;
    localparam logic [1:0] EXP_MISS   = 2'd0;
    localparam logic [1:0] EXP_HIT    = 2'd1;
    localparam logic [1:0] EXP_ANY    = 2'd2;

    typedef struct packed {
        logic       wr;
        addr_t      addr;
        word_t      data;
        sel_t       sel;
        logic [1:0] expect_hit;
    } step_t;

    logic  clk;
    logic  rst;
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t dat_w;
    sel_t  sel;
    word_t dat_r;
    logic  ack;
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_adr;
    word_t mem_dat_w;
    word_t mem_dat_r;
    logic  mem_ack;

    word_t ref_mem [MEM_WORDS];
    step_t steps[$];
    addr_t wb_log[$];
    int    wb_check_at = -1;
    int    cycle_cnt   = 0;
    int    cycle_limit = 1000;

    clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    dcache_top DUT (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .sel       (sel),
        .dat_r     (dat_r),
        .ack       (ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    mem_model #(
        .FILL_KEY (FILL_KEY),
        .MAX_WAIT (MAX_WAIT)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    function automatic int word_idx(input addr_t a);
        return int'(a[BYTE_BITS +: 14]);
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_step(input logic wr, input addr_t a, input word_t d, input sel_t s,
                            input logic [1:0] h);
        step_t st;
        st.wr         = wr;
        st.addr       = a;
        st.data       = d;
        st.sel        = s;
        st.expect_hit = h;
        steps.push_back(st);
    endtask

    // reference store of the byte lanes enabled by sel
    task automatic store_ref(input addr_t a, input word_t d, input sel_t s);
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (s[b]) begin
                ref_mem[word_idx(a)][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    // called right after a rising edge
    task automatic run_step(input step_t s);
        int    lat;
        word_t rd;
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= s.wr;
        adr   <= s.addr;
        dat_w <= s.data;
        sel   <= s.sel;
        // first edge sees the request in idle
        @(posedge clk);
        lat = 0;
        while (!ack) begin
            @(posedge clk);
            lat++;
        end
        rd = dat_r;
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        if (s.expect_hit != EXP_ANY) begin
            check_bit("ack_after_2_cycles", lat == HIT_CYCLES, s.expect_hit[0]);
        end
        if (s.wr) begin
            store_ref(s.addr, s.data, s.sel);
        end else begin
            check_word("dat_r", rd, ref_mem[word_idx(s.addr)]);
        end
    endtask

    task automatic check_writeback(input addr_t line);
        if (wb_log.size() != LINE_WORDS) begin
            $display("expected %0d writeback cycles, memory saw %0d", LINE_WORDS, wb_log.size());
            abort_run();
        end
        foreach (wb_log[k]) begin
            check_addr("mem_adr", wb_log[k], line + addr_t'(4 * k));
            check_word("memory word", u_mem.store[word_idx(wb_log[k])],
                       ref_mem[word_idx(wb_log[k])]);
        end
        wb_log.delete();
    endtask

    // every memory write must carry the current reference word
    always @(posedge clk) begin
        if (!rst && mem_cyc) begin
            if (mem_adr >= addr_t'(4 * MEM_WORDS)) begin
                $display("memory access at %h lies outside the memory model", mem_adr);
                abort_run();
            end
            if (mem_stb && mem_we && mem_ack) begin
                wb_log.push_back(mem_adr);
                check_word("mem_dat_w", mem_dat_w, ref_mem[word_idx(mem_adr)]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, a request got no ack", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        addr_t a;
        void'($urandom(32'hdc4f));
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = word_t'(i) ^ FILL_KEY;
        end

        // read miss then a hit in the same line
        add_step(1'b0, 32'h0000_0024, '0, 4'hf, EXP_MISS);
        add_step(1'b0, 32'h0000_0030, '0, 4'hf, EXP_HIT);
        // partial store hit and a store miss with allocate
        add_step(1'b1, 32'h0000_0028, 32'hdead_beef, 4'b0101, EXP_HIT);
        add_step(1'b0, 32'h0000_0028, '0, 4'hf, EXP_HIT);
        add_step(1'b1, 32'h0000_0848, 32'h1234_5678, 4'b1100, EXP_MISS);
        add_step(1'b0, 32'h0000_0848, '0, 4'hf, EXP_HIT);
        // A stored then B then C evicts dirty A in set 3
        add_step(1'b1, LINE_A + 4, 32'ha5a5_0001, 4'hf, EXP_MISS);
        add_step(1'b0, 32'h0000_2060, '0, 4'hf, EXP_MISS);
        add_step(1'b0, 32'h0000_3060, '0, 4'hf, EXP_MISS);
        wb_check_at = steps.size() - 1;
        add_step(1'b0, LINE_A + 4, '0, 4'hf, EXP_MISS);
        // D E D F in set 5 keeps D and drops E
        add_step(1'b0, 32'h0000_10a0, '0, 4'hf, EXP_MISS);
        add_step(1'b0, 32'h0000_20a0, '0, 4'hf, EXP_MISS);
        add_step(1'b0, 32'h0000_10a4, '0, 4'hf, EXP_HIT);
        add_step(1'b0, 32'h0000_30a0, '0, 4'hf, EXP_MISS);
        add_step(1'b0, 32'h0000_10a8, '0, 4'hf, EXP_HIT);
        add_step(1'b0, 32'h0000_20a8, '0, 4'hf, EXP_MISS);
        // random mix over four tags and a few sets
        for (int k = 0; k < RAND_STEPS; k++) begin
            a = addr_t'(($urandom_range(3, 0) << 12) | ($urandom_range(4, 1) << 5)
                        | ($urandom_range(7, 0) << 2));
            add_step(1'($urandom_range(1, 0)), a, $urandom, sel_t'($urandom_range(15, 1)),
                     EXP_ANY);
        end
        cycle_limit = 20 + steps.size() * (MISS_WORST + 2);

        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        repeat (3) begin
            check_bit("ack", ack, 1'b0);
            check_bit("mem_cyc", mem_cyc, 1'b0);
            check_bit("mem_stb", mem_stb, 1'b0);
            check_bit("mem_we", mem_we, 1'b0);
            @(posedge clk);
        end

        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            if (i == wb_check_at) begin
                check_writeback(LINE_A);
            end
            @(posedge clk);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`default_nettype none

module mem_model #(
    parameter dcache_pkg::word_t FILL_KEY = 32'h0,
    parameter int                MAX_WAIT = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_cyc,
    input  logic              mem_stb,
    input  logic              mem_we,
    input  dcache_pkg::addr_t mem_adr,
    input  dcache_pkg::word_t mem_dat_w,
    output dcache_pkg::word_t mem_dat_r,
    output logic              mem_ack
);
    timeunit 1ns;
    timeprecision 1ns;
    import dcache_pkg::*;

    localparam int DEPTH_BITS = 14;

    // backing store for the low 64 KiB
    word_t       store [1 << DEPTH_BITS];
    logic        busy;
    int unsigned wait_left;

    initial begin
        mem_ack   = 1'b0;
        mem_dat_r = '0;
        for (int i = 0; i < (1 << DEPTH_BITS); i++) begin
            store[i] = word_t'(i) ^ FILL_KEY;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            mem_dat_r <= '0;
            busy      <= 1'b0;
            wait_left <= 0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_cyc && mem_stb && !mem_ack) begin
                if (!busy) begin
                    busy      <= 1'b1;
                    wait_left <= $urandom_range(MAX_WAIT, 0);
                end else if (wait_left != 0) begin
                    wait_left <= wait_left - 1;
                end else begin
                    busy      <= 1'b0;
                    mem_ack   <= 1'b1;
                    mem_dat_r <= store[mem_adr[BYTE_BITS +: DEPTH_BITS]];
                    if (mem_we) begin
                        store[mem_adr[BYTE_BITS +: DEPTH_BITS]] <= mem_dat_w;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cache_arrays.sv
`default_nettype none

module cache_arrays (
    input  logic                              clk,
    input  logic                              rst,
    input  dcache_pkg::index_t                rd_index,
    input  dcache_pkg::offset_t               rd_offset,
    output dcache_pkg::tag_t                  rd_tag0,
    output dcache_pkg::tag_t                  rd_tag1,
    output dcache_pkg::word_t                 rd_data0,
    output dcache_pkg::word_t                 rd_data1,
    output logic [dcache_pkg::NUM_WAYS-1:0]   rd_valid,
    output logic [dcache_pkg::NUM_WAYS-1:0]   rd_dirty,
    output dcache_pkg::way_t                  rd_lru,
    input  dcache_pkg::index_t                wr_index,
    input  dcache_pkg::offset_t               wr_offset,
    input  dcache_pkg::way_t                  wr_way,
    input  dcache_pkg::word_t                 wr_data,
    input  dcache_pkg::sel_t                  wr_sel,
    input  logic                              tag_we,
    input  dcache_pkg::tag_t                  wr_tag,
    input  logic                              meta_we,
    input  logic                              set_dirty,
    input  dcache_pkg::way_t                  new_lru
);
    import dcache_pkg::*;

    tag_t  tag_mem  [NUM_WAYS][NUM_SETS];
    word_t data_mem [NUM_WAYS][NUM_SETS][LINE_WORDS];

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_bits;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_bits;
    // lru bit names the way to replace next
    logic [NUM_SETS-1:0]               lru_bits;

    // tag and data storage, read-first
    always_ff @(posedge clk) begin
        rd_tag0  <= tag_mem[0][rd_index];
        rd_tag1  <= tag_mem[1][rd_index];
        rd_data0 <= data_mem[0][rd_index][rd_offset];
        rd_data1 <= data_mem[1][rd_index][rd_offset];
        rd_valid <= valid_bits[rd_index];
        rd_dirty <= dirty_bits[rd_index];
        rd_lru   <= lru_bits[rd_index];

        if (tag_we) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (wr_sel[b]) begin
                data_mem[wr_way][wr_index][wr_offset][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // per-set state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            lru_bits   <= '0;
        end else if (meta_we) begin
            valid_bits[wr_index][wr_way] <= 1'b1;
            dirty_bits[wr_index][wr_way] <= set_dirty;
            lru_bits[wr_index]           <= new_lru;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  dcache_pkg::addr_t               adr,
    input  dcache_pkg::word_t               dat_w,
    input  dcache_pkg::sel_t                sel,
    output dcache_pkg::word_t               dat_r,
    output logic                            ack,
    output dcache_pkg::index_t              rd_index,
    output dcache_pkg::offset_t             rd_offset,
    input  dcache_pkg::tag_t                rd_tag0,
    input  dcache_pkg::tag_t                rd_tag1,
    input  dcache_pkg::word_t               rd_data0,
    input  dcache_pkg::word_t               rd_data1,
    input  logic [dcache_pkg::NUM_WAYS-1:0] rd_valid,
    input  logic [dcache_pkg::NUM_WAYS-1:0] rd_dirty,
    input  dcache_pkg::way_t                rd_lru,
    output dcache_pkg::index_t              wr_index,
    output dcache_pkg::offset_t             wr_offset,
    output dcache_pkg::way_t                wr_way,
    output dcache_pkg::word_t               wr_data,
    output dcache_pkg::sel_t                wr_sel,
    output logic                            tag_we,
    output dcache_pkg::tag_t                wr_tag,
    output logic                            meta_we,
    output logic                            set_dirty,
    output dcache_pkg::way_t                new_lru,
    output logic                            mv_start,
    output logic                            mv_evict,
    output dcache_pkg::way_t                mv_way,
    output dcache_pkg::index_t              mv_index,
    output dcache_pkg::tag_t                mv_tag,
    input  dcache_pkg::offset_t             mv_rd_offset,
    output dcache_pkg::word_t               mv_rd_data,
    input  logic                            fill_valid,
    input  dcache_pkg::offset_t             fill_offset,
    input  dcache_pkg::word_t               fill_data,
    input  logic                            mv_done
);
    import dcache_pkg::*;

    ctrl_state_t state;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    req_we;
    word_t   req_dat;
    sel_t    req_sel;
    way_t    victim_way;
    word_t   rdata;

    logic    hit0;
    logic    hit1;
    logic    hit;
    way_t    hit_way;
    word_t   hit_data;
    logic    victim_dirty;
    logic    fill_hit;
    word_t   fill_word;

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, sel_t be);
        word_t res;
        res = old_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign hit0     = rd_valid[0] && (rd_tag0 == req_tag);
    assign hit1     = rd_valid[1] && (rd_tag1 == req_tag);
    assign hit      = hit0 || hit1;
    assign hit_way  = hit1;
    assign hit_data = hit1 ? rd_data1 : rd_data0;

    assign victim_dirty = rd_valid[rd_lru] && rd_dirty[rd_lru];

    // the requested word picks up the store bytes on its way into the line
    assign fill_hit  = fill_valid && (fill_offset == req_offset);
    assign fill_word = (fill_hit && req_we) ? merge_bytes(fill_data, req_dat, req_sel)
                                            : fill_data;

    // arrays are read straight from the bus address while idle
    assign rd_index  = (state == IDLE) ? adr[BYTE_BITS+OFFSET_BITS +: INDEX_BITS] : req_index;
    assign rd_offset = (state == EVICT) ? mv_rd_offset :
                       (state == IDLE)  ? adr[BYTE_BITS +: OFFSET_BITS] : req_offset;

    assign mv_start   = ((state == LOOKUP) && !hit) || ((state == EVICT) && mv_done);
    assign mv_evict   = (state == LOOKUP) && victim_dirty;
    assign mv_way     = (state == LOOKUP) ? rd_lru : victim_way;
    assign mv_index   = req_index;
    assign mv_tag     = mv_evict ? (rd_lru ? rd_tag1 : rd_tag0) : req_tag;
    assign mv_rd_data = victim_way ? rd_data1 : rd_data0;

    assign wr_index = req_index;
    assign wr_tag   = req_tag;

    always_comb begin
        wr_offset = req_offset;
        wr_way    = victim_way;
        wr_data   = req_dat;
        wr_sel    = '0;
        tag_we    = 1'b0;
        meta_we   = 1'b0;
        set_dirty = req_we;
        new_lru   = ~victim_way;
        case (state)
            LOOKUP: begin
                if (hit) begin
                    wr_way    = hit_way;
                    wr_sel    = req_we ? req_sel : '0;
                    meta_we   = 1'b1;
                    set_dirty = req_we || rd_dirty[hit_way];
                    new_lru   = ~hit_way;
                end
            end
            REFILL: begin
                wr_offset = fill_offset;
                wr_data   = fill_word;
                wr_sel    = fill_valid ? '1 : '0;
                tag_we    = mv_done;
                meta_we   = mv_done;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                IDLE: begin
                    if (cyc && stb) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state <= RESPOND;
                        ack   <= 1'b1;
                    end else begin
                        state <= victim_dirty ? EVICT : REFILL;
                    end
                end
                EVICT: begin
                    if (mv_done) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (mv_done) begin
                        state <= RESPOND;
                        ack   <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cyc && stb) begin
            req_tag    <= adr[ADDR_BITS-1 -: TAG_BITS];
            req_index  <= adr[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
            req_offset <= adr[BYTE_BITS +: OFFSET_BITS];
            req_we     <= we;
            req_dat    <= dat_w;
            req_sel    <= sel;
        end
        if (state == LOOKUP) begin
            victim_way <= rd_lru;
            rdata      <= hit_data;
        end
        if (fill_hit) begin
            rdata <= fill_word;
        end
    end

    assign dat_r = rdata;

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> cyc);

endmodule

`default_nettype wire

// File: hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int ADDR_BITS   = 32;
    localparam int WORD_BYTES  = 4;
    localparam int LINE_WORDS  = 8;
    localparam int INDEX_BITS  = 7;
    localparam int NUM_WAYS    = 2;

    localparam int BYTE_BITS   = $clog2(WORD_BYTES);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS - BYTE_BITS;
    localparam int NUM_SETS    = 1 << INDEX_BITS;

    typedef logic [ADDR_BITS-1:0]        addr_t;
    typedef logic [8*WORD_BYTES-1:0]     word_t;
    typedef logic [WORD_BYTES-1:0]       sel_t;
    typedef logic [TAG_BITS-1:0]         tag_t;
    typedef logic [INDEX_BITS-1:0]       index_t;
    typedef logic [OFFSET_BITS-1:0]      offset_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // lookup and miss sequencing
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/dcache_top.sv
`default_nettype none

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  dcache_pkg::addr_t adr,
    input  dcache_pkg::word_t dat_w,
    input  dcache_pkg::sel_t  sel,
    output dcache_pkg::word_t dat_r,
    output logic              ack,
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output dcache_pkg::addr_t mem_adr,
    output dcache_pkg::word_t mem_dat_w,
    input  dcache_pkg::word_t mem_dat_r,
    input  logic              mem_ack
);
    import dcache_pkg::*;

    index_t  rd_index;
    offset_t rd_offset;
    tag_t    rd_tag0;
    tag_t    rd_tag1;
    word_t   rd_data0;
    word_t   rd_data1;
    logic [NUM_WAYS-1:0] rd_valid;
    logic [NUM_WAYS-1:0] rd_dirty;
    way_t    rd_lru;

    index_t  wr_index;
    offset_t wr_offset;
    way_t    wr_way;
    word_t   wr_data;
    sel_t    wr_sel;
    logic    tag_we;
    tag_t    wr_tag;
    logic    meta_we;
    logic    set_dirty;
    way_t    new_lru;

    logic    mv_start;
    logic    mv_evict;
    way_t    mv_way;
    index_t  mv_index;
    tag_t    mv_tag;
    offset_t mv_rd_offset;
    word_t   mv_rd_data;
    logic    fill_valid;
    offset_t fill_offset;
    word_t   fill_data;
    logic    mv_done;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .sel          (sel),
        .dat_r        (dat_r),
        .ack          (ack),
        .rd_index     (rd_index),
        .rd_offset    (rd_offset),
        .rd_tag0      (rd_tag0),
        .rd_tag1      (rd_tag1),
        .rd_data0     (rd_data0),
        .rd_data1     (rd_data1),
        .rd_valid     (rd_valid),
        .rd_dirty     (rd_dirty),
        .rd_lru       (rd_lru),
        .wr_index     (wr_index),
        .wr_offset    (wr_offset),
        .wr_way       (wr_way),
        .wr_data      (wr_data),
        .wr_sel       (wr_sel),
        .tag_we       (tag_we),
        .wr_tag       (wr_tag),
        .meta_we      (meta_we),
        .set_dirty    (set_dirty),
        .new_lru      (new_lru),
        .mv_start     (mv_start),
        .mv_evict     (mv_evict),
        .mv_way       (mv_way),
        .mv_index     (mv_index),
        .mv_tag       (mv_tag),
        .mv_rd_offset (mv_rd_offset),
        .mv_rd_data   (mv_rd_data),
        .fill_valid   (fill_valid),
        .fill_offset  (fill_offset),
        .fill_data    (fill_data),
        .mv_done      (mv_done)
    );

    cache_arrays u_arrays (
        .clk       (clk),
        .rst       (rst),
        .rd_index  (rd_index),
        .rd_offset (rd_offset),
        .rd_tag0   (rd_tag0),
        .rd_tag1   (rd_tag1),
        .rd_data0  (rd_data0),
        .rd_data1  (rd_data1),
        .rd_valid  (rd_valid),
        .rd_dirty  (rd_dirty),
        .rd_lru    (rd_lru),
        .wr_index  (wr_index),
        .wr_offset (wr_offset),
        .wr_way    (wr_way),
        .wr_data   (wr_data),
        .wr_sel    (wr_sel),
        .tag_we    (tag_we),
        .wr_tag    (wr_tag),
        .meta_we   (meta_we),
        .set_dirty (set_dirty),
        .new_lru   (new_lru)
    );

    line_mover u_mover (
        .clk         (clk),
        .rst         (rst),
        .start       (mv_start),
        .evict       (mv_evict),
        .way         (mv_way),
        .index       (mv_index),
        .tag         (mv_tag),
        .rd_data     (mv_rd_data),
        .rd_offset   (mv_rd_offset),
        .fill_valid  (fill_valid),
        .fill_offset (fill_offset),
        .fill_data   (fill_data),
        .done        (mv_done),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_dat_w   (mem_dat_w),
        .mem_dat_r   (mem_dat_r),
        .mem_ack     (mem_ack)
    );

endmodule

`default_nettype wire

// File: hdl/line_mover.sv
`default_nettype none

module line_mover (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                evict,
    input  dcache_pkg::way_t    way,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::word_t   rd_data,
    output dcache_pkg::offset_t rd_offset,
    output logic                fill_valid,
    output dcache_pkg::offset_t fill_offset,
    output dcache_pkg::word_t   fill_data,
    output logic                done,
    output logic                mem_cyc,
    output logic                mem_stb,
    output logic                mem_we,
    output dcache_pkg::addr_t   mem_adr,
    output dcache_pkg::word_t   mem_dat_w,
    input  dcache_pkg::word_t   mem_dat_r,
    input  logic                mem_ack
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {MV_IDLE, MV_READ, MV_BUS, MV_DONE} mv_state_t;

    mv_state_t state;
    offset_t   cnt;
    logic      evict_q;
    index_t    index_q;
    tag_t      tag_q;
    logic      accept;
    logic      last_word;

    // a new line may start in the same cycle that done is shown
    assign accept    = start && (state == MV_IDLE || state == MV_DONE);
    assign last_word = (cnt == offset_t'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= MV_IDLE;
            cnt     <= '0;
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
        end else begin
            case (state)
                MV_IDLE, MV_DONE: begin
                    state <= accept ? MV_READ : MV_IDLE;
                    cnt   <= '0;
                end
                // bus idle gap while the array reads ahead for writeback
                MV_READ: begin
                    state   <= MV_BUS;
                    mem_cyc <= 1'b1;
                    mem_stb <= 1'b1;
                end
                MV_BUS: begin
                    if (mem_ack) begin
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        cnt     <= cnt + 1'b1;
                        state   <= last_word ? MV_DONE : MV_READ;
                    end
                end
                default: state <= MV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            evict_q <= evict;
            index_q <= index;
            tag_q   <= tag;
        end
    end

    assign rd_offset   = cnt;
    assign fill_valid  = (state == MV_BUS) && mem_ack && !evict_q;
    assign fill_offset = cnt;
    assign fill_data   = mem_dat_r;
    assign done        = (state == MV_DONE);

    assign mem_we    = mem_cyc && evict_q;
    assign mem_adr   = {tag_q, index_q, cnt, {BYTE_BITS{1'b0}}};
    assign mem_dat_w = rd_data;

    // a strobe stays up with cyc, address and direction until the slave acks
    stb_held: assert property (@(posedge clk) disable iff (rst)
        (mem_stb && !mem_ack) |=> (mem_stb && mem_cyc && $stable(mem_adr) && $stable(mem_we)));

    // controller keeps the way fixed for a whole line
    way_held: assert property (@(posedge clk) disable iff (rst)
        (state != MV_IDLE) |-> $stable(way));

endmodule

`default_nettype wire

// File: tb.f
hdl/dcache_pkg.sv
hdl/cache_arrays.sv
hdl/line_mover.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/dcache_tb.sv
